// ==== common/la_pkg.sv ====
`default_nettype none

package la_pkg;

        // exception codes, estat.ecode
        localparam logic [5:0] ecode_int = 6'h0;
        localparam logic [5:0] ecode_ade = 6'h8;
        localparam logic [5:0] ecode_ale = 6'h9;
        localparam logic [5:0] ecode_sys = 6'hb;
        localparam logic [5:0] ecode_brk = 6'hc;
        localparam logic [5:0] ecode_ine = 6'hd;

        localparam logic [13:0] csr_crmd   = 14'h0;
        localparam logic [13:0] csr_prmd   = 14'h1;
        localparam logic [13:0] csr_estat  = 14'h5;
        localparam logic [13:0] csr_era    = 14'h6;
        localparam logic [13:0] csr_badv   = 14'h7;
        localparam logic [13:0] csr_eentry = 14'hc;
        localparam logic [13:0] csr_save0  = 14'h30;

        localparam logic [31:0] crmd_rst = 32'h0000_0008; // da=1, plv0, ie off

        // software-writable bits per csr
        localparam logic [31:0] crmd_wmask   = 32'h0000_000f; // plv, ie, da
        localparam logic [31:0] prmd_wmask   = 32'h0000_0007; // pplv, pie
        localparam logic [31:0] estat_wmask  = 32'h0000_0003; // swi bits
        localparam logic [31:0] eentry_wmask = 32'hffff_ffc0;
        localparam logic [31:0] full_wmask   = 32'hffff_ffff; // era, badv, save0

        typedef struct packed {
                logic        valid;
                logic [31:0] pc;
                logic [31:0] inst;
                logic        gr_we;
                logic [4:0]  dest;
                logic [31:0] result;
        } mem_to_wb_t;

        typedef struct packed {
                logic        csr_re;
                logic        csr_we;
                logic [31:0] csr_wmask;
                logic [31:0] csr_wvalue;
                logic [13:0] csr_num;
                logic        ertn;
                logic        ex_sys;
                logic        ex_adef;
                logic        ex_brk;
                logic        ex_ine;
                logic        ex_int;
                logic        ex_ale;
                logic [31:0] vaddr;
        } except_info_t;

        typedef struct packed {
                logic        re;
                logic        we;
                logic [13:0] num;
                logic [31:0] wmask;
                logic [31:0] wvalue;
                logic        ex;        // exception taken this cycle
                logic [5:0]  ecode;
                logic [8:0]  esubcode;
                logic        ertn;
                logic [31:0] pc;
                logic [31:0] vaddr;
                logic        badv_we;
        } csr_req_t;

        typedef struct packed {
                logic        valid;
                logic [31:0] pc;
                logic        we;
                logic [4:0]  waddr;
                logic [31:0] wdata;
        } retire_t;

endpackage

`default_nettype wire

// ==== wb/wb_stage.sv ====
`default_nettype none

module wb_stage import la_pkg::*; (
        input  wire logic         clk,
        input  wire logic         rst_n,
        input  wire mem_to_wb_t   mem_in,
        input  wire except_info_t exc_in,
        input  wire logic [31:0]  csr_rvalue,
        input  wire logic [31:0]  eentry,
        input  wire logic [31:0]  era,
        output csr_req_t          csr_req,
        output logic              rf_we,
        output logic [4:0]        rf_waddr,
        output logic [31:0]       rf_wdata,
        output retire_t           retire,
        output logic              flush,
        output logic [31:0]       flush_target
);

        logic        valid;
        logic        ex;
        logic        ertn_go;
        logic [5:0]  ecode;
        logic        ret_valid;
        logic [31:0] ret_pc;
        logic        ret_we;
        logic [4:0]  ret_waddr;
        logic [31:0] ret_wdata;

        assign valid = mem_in.valid;

        assign ex = valid & (exc_in.ex_sys | exc_in.ex_adef | exc_in.ex_ale |
                             exc_in.ex_brk | exc_in.ex_ine | exc_in.ex_int);
        assign ertn_go = valid & exc_in.ertn & ~ex; // exception wins

        // fixed priority, sys highest
        always_comb begin
                if (exc_in.ex_sys)       ecode = ecode_sys;
                else if (exc_in.ex_adef) ecode = ecode_ade;
                else if (exc_in.ex_ale)  ecode = ecode_ale;
                else if (exc_in.ex_brk)  ecode = ecode_brk;
                else if (exc_in.ex_ine)  ecode = ecode_ine;
                else                     ecode = ecode_int;
        end

        always_comb begin
                csr_req.re       = valid & exc_in.csr_re;
                csr_req.we       = valid & exc_in.csr_we & ~ex;
                csr_req.num      = exc_in.csr_num;
                csr_req.wmask    = exc_in.csr_wmask;
                csr_req.wvalue   = exc_in.csr_wvalue;
                csr_req.ex       = ex;
                csr_req.ecode    = ecode;
                csr_req.esubcode = 9'd0;
                csr_req.ertn     = ertn_go;
                csr_req.pc       = mem_in.pc;
                csr_req.vaddr    = exc_in.vaddr;
                csr_req.badv_we  = ex & (ecode == ecode_ade || ecode == ecode_ale);
        end

        assign rf_we    = valid & mem_in.gr_we & ~ex;
        assign rf_waddr = mem_in.dest;
        assign rf_wdata = exc_in.csr_re ? csr_rvalue : mem_in.result;

        assign flush        = ex | ertn_go;
        assign flush_target = ex ? eentry : era;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        ret_valid <= 1'b0;
                else
                        ret_valid <= valid;
        end

        always_ff @(posedge clk) begin
                ret_pc    <= mem_in.pc;
                ret_we    <= rf_we;    // low for excepting items
                ret_waddr <= rf_waddr;
                ret_wdata <= rf_wdata;
        end

        assign retire = '{valid: ret_valid, pc: ret_pc, we: ret_we,
                          waddr: ret_waddr, wdata: ret_wdata};

endmodule

`default_nettype wire

// ==== wb/csr_file.sv ====
`default_nettype none

module csr_file import la_pkg::*; (
        input  wire logic     clk,
        input  wire logic     rst_n,
        input  wire csr_req_t req,
        output logic [31:0]   rvalue,
        output logic [31:0]   eentry,
        output logic [31:0]   era
);

        logic [31:0] crmd;
        logic [31:0] prmd;
        logic [31:0] estat;
        logic [31:0] badv;
        logic [31:0] save0;
        logic [31:0] rd_val;
        logic        wr_ok;
        logic        wr_crmd;
        logic        wr_prmd;
        logic        wr_estat;
        logic        wr_era;
        logic        wr_badv;
        logic        wr_eentry;
        logic        wr_save0;

        // old bits where mask clear, new where set and writable
        function automatic logic [31:0] merge(input logic [31:0] old,
                                              input logic [31:0] reg_mask);
                logic [31:0] m;
                m = req.wmask & reg_mask;
                return (old & ~m) | (req.wvalue & m);
        endfunction

        always_comb begin
                case (req.num)
                        csr_crmd:   rd_val = crmd;
                        csr_prmd:   rd_val = prmd;
                        csr_estat:  rd_val = estat;
                        csr_era:    rd_val = era;
                        csr_badv:   rd_val = badv;
                        csr_eentry: rd_val = eentry;
                        csr_save0:  rd_val = save0;
                        default:    rd_val = 32'h0; // unknown csr
                endcase
        end

        assign rvalue = req.re ? rd_val : 32'h0;

        // exception entry and ertn block software writes
        assign wr_ok     = req.we & ~req.ex & ~req.ertn;
        assign wr_crmd   = wr_ok & (req.num == csr_crmd);
        assign wr_prmd   = wr_ok & (req.num == csr_prmd);
        assign wr_estat  = wr_ok & (req.num == csr_estat);
        assign wr_era    = wr_ok & (req.num == csr_era);
        assign wr_badv   = wr_ok & (req.num == csr_badv);
        assign wr_eentry = wr_ok & (req.num == csr_eentry);
        assign wr_save0  = wr_ok & (req.num == csr_save0);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        crmd <= crmd_rst;
                else if (req.ex)
                        crmd <= {crmd[31:3], 3'b000};   // plv0, ie off
                else if (req.ertn)
                        crmd <= {crmd[31:3], prmd[2:0]};
                else if (wr_crmd)
                        crmd <= merge(crmd, crmd_wmask);
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        prmd <= 32'h0;
                else if (req.ex)
                        prmd <= {prmd[31:3], crmd[2:0]}; // save plv and ie
                else if (wr_prmd)
                        prmd <= merge(prmd, prmd_wmask);
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        estat <= 32'h0;
                else if (req.ex)
                        estat <= {estat[31], req.esubcode, req.ecode, estat[15:0]};
                else if (wr_estat)
                        estat <= merge(estat, estat_wmask);
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        era <= 32'h0;
                else if (req.ex)
                        era <= req.pc;
                else if (wr_era)
                        era <= merge(era, full_wmask);
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        badv <= 32'h0;
                else if (req.ex && req.badv_we)
                        badv <= req.vaddr; // ade and ale only
                else if (wr_badv)
                        badv <= merge(badv, full_wmask);
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        eentry <= 32'h0;
                        save0  <= 32'h0;
                end else begin
                        if (wr_eentry)
                                eentry <= merge(eentry, eentry_wmask);
                        if (wr_save0)
                                save0 <= merge(save0, full_wmask);
                end
        end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`default_nettype none

module reg_file (
        input  wire logic        clk,
        input  wire logic        rst_n,
        input  wire logic        we,
        input  wire logic [4:0]  waddr,
        input  wire logic [31:0] wdata,
        input  wire logic [4:0]  raddr1,
        input  wire logic [4:0]  raddr2,
        output logic [31:0]      rdata1,
        output logic [31:0]      rdata2
);

        logic [31:0] regs [1:31]; // no storage behind r0

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 1; i < 32; i++) begin
                                regs[i] <= 32'h0;
                        end
                end else if (we && waddr != 5'd0) begin
                        regs[waddr] <= wdata;
                end
        end

        always_comb begin
                if (raddr1 == 5'd0)
                        rdata1 = 32'h0;
                else
                        rdata1 = regs[raddr1];
        end

        always_comb begin
                if (raddr2 == 5'd0)
                        rdata2 = 32'h0;
                else
                        rdata2 = regs[raddr2];
        end

endmodule

`default_nettype wire

// ==== verilog/wb_subsys.sv ====
`default_nettype none

module wb_subsys import la_pkg::*; (
        input  wire logic         clk,
        input  wire logic         rst_n,
        input  wire mem_to_wb_t   mem_in,
        input  wire except_info_t exc_in,
        input  wire logic [4:0]   raddr1,
        input  wire logic [4:0]   raddr2,
        output logic [31:0]       rdata1,
        output logic [31:0]       rdata2,
        output retire_t           retire,
        output logic              flush,
        output logic [31:0]       flush_target
);

        csr_req_t    csr_req;
        logic [31:0] csr_rvalue;
        logic [31:0] eentry;
        logic [31:0] era;
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] rf_wdata;

        wb_stage u_wb_stage (
                .clk          (clk),
                .rst_n        (rst_n),
                .mem_in       (mem_in),
                .exc_in       (exc_in),
                .csr_rvalue   (csr_rvalue),
                .eentry       (eentry),
                .era          (era),
                .csr_req      (csr_req),
                .rf_we        (rf_we),
                .rf_waddr     (rf_waddr),
                .rf_wdata     (rf_wdata),
                .retire       (retire),
                .flush        (flush),
                .flush_target (flush_target)
        );

        csr_file u_csr_file (
                .clk    (clk),
                .rst_n  (rst_n),
                .req    (csr_req),
                .rvalue (csr_rvalue),   // read path back into the stage
                .eentry (eentry),
                .era    (era)
        );

        reg_file u_reg_file (
                .clk    (clk),
                .rst_n  (rst_n),
                .we     (rf_we),
                .waddr  (rf_waddr),
                .wdata  (rf_wdata),
                .raddr1 (raddr1),
                .raddr2 (raddr2),
                .rdata1 (rdata1),
                .rdata2 (rdata2)
        );

endmodule

`default_nettype wire

// ==== verif/wb_subsys_chk.sv ====
`default_nettype none

module wb_subsys_chk import la_pkg::*; (
        input wire logic         clk,
        input wire logic         rst_n,
        input wire mem_to_wb_t   mem_in,
        input wire except_info_t exc_in,
        input wire csr_req_t     csr_req,
        input wire logic         rf_we,
        input wire retire_t      retire,
        input wire logic         flush
);

        int fail_cnt = 0;

        // nothing retires or flushes while in reset
        a_reset_quiet: assert property (@(posedge clk)
                !rst_n |-> (!retire.valid && !flush))
                else begin
                        fail_cnt++;
                        $error("retire or flush active during reset");
                end

        // retire record follows the input item by one cycle
        a_retire_follows: assert property (@(posedge clk) disable iff (!rst_n)
                mem_in.valid |=> retire.valid)
                else begin
                        fail_cnt++;
                        $error("valid item did not retire");
                end

        a_retire_idle: assert property (@(posedge clk) disable iff (!rst_n)
                !mem_in.valid |=> !retire.valid)
                else begin
                        fail_cnt++;
                        $error("retire without a valid item");
                end

        // an excepting item commits no register
        a_flush_no_commit: assert property (@(posedge clk) disable iff (!rst_n)
                csr_req.ex |-> (flush && !rf_we))
                else begin
                        fail_cnt++;
                        $error("register write during exception flush");
                end

        // invalid items touch nothing
        a_invalid_quiet: assert property (@(posedge clk) disable iff (!rst_n)
                !mem_in.valid |-> (!flush && !rf_we && !csr_req.we))
                else begin
                        fail_cnt++;
                        $error("invalid item had an effect");
                end

        // sys outranks the other flags
        a_sys_first: assert property (@(posedge clk) disable iff (!rst_n)
                (mem_in.valid && exc_in.ex_sys) |-> (flush && csr_req.ecode == ecode_sys))
                else begin
                        fail_cnt++;
                        $error("sys exception lost priority");
                end

        a_retire_no_we: assert property (@(posedge clk) disable iff (!rst_n)
                (mem_in.valid && csr_req.ex) |=> (retire.valid && !retire.we))
                else begin
                        fail_cnt++;
                        $error("excepting item retired with a write");
                end

endmodule

bind wb_subsys wb_subsys_chk u_chk (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_in  (mem_in),
        .exc_in  (exc_in),
        .csr_req (csr_req),
        .rf_we   (rf_we),
        .retire  (retire),
        .flush   (flush)
);

`default_nettype wire

// ==== verif/tb_wb_subsys.sv ====
`default_nettype none

module tb_wb_subsys import la_pkg::*; ();

        logic         clk;
        logic         rst_n;
        mem_to_wb_t   mem_in;
        except_info_t exc_in;
        logic [4:0]   raddr1;
        logic [4:0]   raddr2;
        logic [31:0]  rdata1;
        logic [31:0]  rdata2;
        retire_t      retire;
        logic         flush;
        logic [31:0]  flush_target;

        integer      seed;
        integer      errors;
        integer      checks;
        logic [31:0] pc_ctr;
        logic [31:0] gr [0:31];
        logic [31:0] m_crmd;
        logic [31:0] m_prmd;
        logic [31:0] m_estat;
        logic [31:0] m_era;
        logic [31:0] m_badv;
        logic [31:0] m_eentry;
        logic [31:0] m_save0;
        retire_t     exp_ret;

        wb_subsys uut (.*);

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        function automatic logic [31:0] csr_read(input logic [13:0] num);
                case (num)
                        csr_crmd:   return m_crmd;
                        csr_prmd:   return m_prmd;
                        csr_estat:  return m_estat;
                        csr_era:    return m_era;
                        csr_badv:   return m_badv;
                        csr_eentry: return m_eentry;
                        csr_save0:  return m_save0;
                        default:    return 32'h0;
                endcase
        endfunction

        function automatic logic [31:0] masked(input logic [31:0] old, input except_info_t e,
                                               input logic [31:0] rm);
                return (old & ~(e.csr_wmask & rm)) | (e.csr_wvalue & e.csr_wmask & rm);
        endfunction

        task automatic check32(input string name, input logic [31:0] exp, input logic [31:0] got);
                checks++;
                if (exp !== got) begin
                        errors++;
                        $display("FAILED t=%0t %s exp=%h got=%h", $time, name, exp, got);
                end
        endtask

        task automatic drive_item(input mem_to_wb_t m, input except_info_t e);
                logic        ex;
                logic        ertn_go;
                logic [5:0]  ec;
                logic [31:0] wd;
                @(posedge clk);
                mem_in <= m;
                exc_in <= e;
                raddr1 <= 5'($random(seed));
                raddr2 <= 5'($random(seed));
                @(negedge clk);
                check32("retire.valid", 32'(exp_ret.valid), 32'(retire.valid));
                if (exp_ret.valid) begin
                        check32("retire.pc", exp_ret.pc, retire.pc);
                        check32("retire.we", 32'(exp_ret.we), 32'(retire.we));
                        if (exp_ret.we) begin
                                check32("retire.waddr", 32'(exp_ret.waddr), 32'(retire.waddr));
                                check32("retire.wdata", exp_ret.wdata, retire.wdata);
                        end
                end
                check32("rdata1", gr[raddr1], rdata1);
                check32("rdata2", gr[raddr2], rdata2);
                ex = m.valid & (e.ex_sys | e.ex_adef | e.ex_ale | e.ex_brk | e.ex_ine | e.ex_int);
                ertn_go = m.valid & e.ertn & ~ex;
                if (e.ex_sys)       ec = 6'hb;
                else if (e.ex_adef) ec = 6'h8;
                else if (e.ex_ale)  ec = 6'h9;
                else if (e.ex_brk)  ec = 6'hc;
                else if (e.ex_ine)  ec = 6'hd;
                else                ec = 6'h0;
                check32("flush", 32'(ex | ertn_go), 32'(flush));
                if (ex)
                        check32("flush_target", m_eentry, flush_target);
                else if (ertn_go)
                        check32("flush_target", m_era, flush_target);
                wd = e.csr_re ? csr_read(e.csr_num) : m.result;
                exp_ret = '{valid: m.valid, pc: m.pc, we: m.valid & m.gr_we & ~ex,
                            waddr: m.dest, wdata: wd};
                if (exp_ret.we && m.dest != 5'd0)
                        gr[m.dest] = wd;
                if (ex) begin
                        m_prmd[2:0] = m_crmd[2:0]; // before crmd clears
                        m_crmd[2:0] = 3'b000;
                        m_era = m.pc;
                        m_estat[30:16] = {9'd0, ec};
                        if (ec == 6'h8 || ec == 6'h9)
                                m_badv = e.vaddr;
                end else if (ertn_go) begin
                        m_crmd[2:0] = m_prmd[2:0];
                end else if (m.valid && e.csr_we) begin
                        case (e.csr_num)
                                csr_crmd:   m_crmd = masked(m_crmd, e, 32'hf);
                                csr_prmd:   m_prmd = masked(m_prmd, e, 32'h7);
                                csr_estat:  m_estat = masked(m_estat, e, 32'h3);
                                csr_era:    m_era = masked(m_era, e, '1);
                                csr_badv:   m_badv = masked(m_badv, e, '1);
                                csr_eentry: m_eentry = masked(m_eentry, e, 32'hffff_ffc0);
                                csr_save0:  m_save0 = masked(m_save0, e, '1);
                                default:    ;
                        endcase
                end
        endtask

        task automatic plain_item(input logic [4:0] dest, input logic [31:0] result);
                mem_to_wb_t m;
                m = '{valid: 1'b1, pc: pc_ctr, inst: $random(seed), gr_we: 1'b1,
                      dest: dest, result: result};
                pc_ctr += 4;
                drive_item(m, '0);
        endtask

        task automatic csr_item(input logic [13:0] num, input logic re, input logic we,
                                input logic [31:0] wm, input logic [31:0] wv,
                                input logic [4:0] dest);
                mem_to_wb_t   m;
                except_info_t e;
                m = '{valid: 1'b1, pc: pc_ctr, inst: $random(seed), gr_we: re,
                      dest: dest, result: $random(seed)};
                e = '0;
                e.csr_re = re;
                e.csr_we = we;
                e.csr_num = num;
                e.csr_wmask = wm;
                e.csr_wvalue = wv;
                pc_ctr += 4;
                drive_item(m, e);
        endtask

        task automatic except_item(input logic [5:0] flags, input logic ertn);
                mem_to_wb_t   m;
                except_info_t e;
                m = '{valid: 1'b1, pc: pc_ctr, inst: $random(seed), gr_we: 1'b1,
                      dest: 5'($random(seed)), result: $random(seed)};
                e = '{csr_re: 1'b0, csr_we: 1'($random(seed)), csr_wmask: $random(seed),
                      csr_wvalue: $random(seed), csr_num: csr_save0, ertn: ertn,
                      ex_sys: flags[5], ex_adef: flags[4], ex_brk: flags[3],
                      ex_ine: flags[2], ex_int: flags[1], ex_ale: flags[0],
                      vaddr: $random(seed)};
                pc_ctr += 4;
                drive_item(m, e);
        endtask

        task automatic wait_idle();
                int n;
                n = 0;
                while (retire.valid || flush) begin
                        @(negedge clk);
                        n++;
                        if (n > 8) begin
                                $display("timeout: retire or flush never went idle");
                                errors++;
                                break;
                        end
                end
        endtask

        initial begin
                mem_to_wb_t   m;
                except_info_t e;
                logic [127:0] rnd;
                seed = 70001;
                errors = 0;
                checks = 0;
                pc_ctr = 32'h1c00_0000;
                rst_n = 1'b0;
                mem_in = '0;
                exc_in = '0;
                raddr1 = 5'd0;
                raddr2 = 5'd0;
                for (int i = 0; i < 32; i++)
                        gr[i] = 32'h0;
                {m_prmd, m_estat, m_era, m_badv, m_eentry, m_save0} = '0;
                m_crmd = 32'h8;
                exp_ret = '0;
                for (int i = 0; i < 16; i++)
                        @(posedge clk);
                rst_n <= 1'b1;
                @(negedge clk);
                check32("retire.valid", 32'h0, 32'(retire.valid));
                check32("flush", 32'h0, 32'(flush));
                csr_item(csr_crmd, 1'b1, 1'b0, '0, '0, 5'd1); // reset value into r1
                for (int i = 0; i < 24; i++)
                        plain_item(5'($random(seed)), $random(seed));
                plain_item(5'd0, 32'hdead_beef); // r0 stays zero
                csr_item(csr_save0, 1'b0, 1'b1, $random(seed), $random(seed), 5'd0);
                csr_item(csr_eentry, 1'b0, 1'b1, 32'hffff_ffff, 32'h1c00_8abc, 5'd0);
                csr_item(csr_crmd, 1'b0, 1'b1, 32'h0000_00ff, 32'hffff_fff7, 5'd0);
                csr_item(csr_save0, 1'b1, 1'b0, '0, '0, 5'd2);
                csr_item(csr_eentry, 1'b1, 1'b0, '0, '0, 5'd3);
                csr_item(csr_crmd, 1'b1, 1'b0, '0, '0, 5'd4);
                csr_item(14'h3ff, 1'b1, 1'b1, '1, '1, 5'd5); // unknown csr
                for (int i = 0; i < 30; i++) begin
                        csr_item(csr_crmd, 1'b0, 1'b1, 32'h7, $random(seed), 5'd0);
                        except_item(6'($random(seed)), 1'($random(seed)));
                        csr_item(csr_estat, 1'b1, 1'b0, '0, '0, 5'd6);
                        csr_item(csr_era, 1'b1, 1'b0, '0, '0, 5'd7);
                        csr_item(csr_badv, 1'b1, 1'b0, '0, '0, 5'd8);
                        csr_item(csr_prmd, 1'b1, 1'b0, '0, '0, 5'd9);
                        except_item(6'h00, 1'b1); // ertn
                        csr_item(csr_crmd, 1'b1, 1'b0, '0, '0, 5'd10);
                end
                for (int i = 0; i < 20; i++) begin
                        rnd = {$random(seed), $random(seed), $random(seed), $random(seed)};
                        m = rnd[$bits(mem_to_wb_t)-1:0];
                        rnd = {$random(seed), $random(seed), $random(seed), $random(seed)};
                        e = rnd[$bits(except_info_t)-1:0];
                        m.valid = 1'b0;
                        drive_item(m, e);
                end
                csr_item(csr_crmd, 1'b1, 1'b0, '0, '0, 5'd11);
                drive_item('0, '0);
                wait_idle();
                $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                         uut.u_chk.fail_cnt);
                if (errors == 0 && uut.u_chk.fail_cnt == 0)
                        $display("Simulation PASSED");
                else
                        $display("Simulation FAILED");
                $finish;
        end

endmodule

`default_nettype wire

// ==== all.f ====
common/la_pkg.sv
wb/wb_stage.sv
wb/csr_file.sv
verilog/reg_file.sv
verilog/wb_subsys.sv
verif/wb_subsys_chk.sv
verif/tb_wb_subsys.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_wb_subsys
FILELIST  = all.f
OBJDIR    = obj_dir
PASS_MSG  = Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
